// ==== sources.f ====
+incdir+verification
verilog/udp_port_pkg.sv
verilog/slot_if.sv
verilog/fcs_checker.sv
verilog/receive_controller.sv
verilog/payload_fifo.sv
verilog/payload_drain.sv
verilog/udp_receive_port.sv
verification/udp_receive_port_tb.sv

// ==== Bender.yml ====
package:
  name: udp_receive_port

sources:
  - verilog/udp_port_pkg.sv
  - verilog/slot_if.sv
  - verilog/fcs_checker.sv
  - verilog/receive_controller.sv
  - verilog/payload_fifo.sv
  - verilog/payload_drain.sv
  - verilog/udp_receive_port.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/udp_receive_port_tb.sv

// ==== verification/frame_builder.svh ====
`ifndef FRAME_BUILDER_SVH
`define FRAME_BUILDER_SVH

// 32-bit xorshift shared by payload bytes and ready patterns
function automatic logic [31:0] xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

// Bitwise Ethernet CRC-32 with the final complement
function automatic crc_t frame_crc();
    crc_t   crc;
    logic   feedback;
    crc = CRC_INIT;
    foreach (frame[i]) begin
        for (int k = 0; k < 8; k++) begin
            feedback = crc[0] ^ frame[i][k];
            crc      = crc >> 1;
            if (feedback) begin
                crc = crc ^ CRC_POLY;
            end
        end
    end
    return ~crc;
endfunction

function automatic void append_fcs();
    crc_t fcs;
    fcs = frame_crc();
    for (int k = 0; k < FCS_BYTES; k++) begin
        frame.push_back(fcs[8*k +: 8]);     // LSB first on the wire
    end
endfunction

function automatic void build_frame(input udp_port_t port, input logic [15:0] ethertype,
                                    input byte_t protocol, input int payload_length);
    byte_t value;
    frame.delete();
    payload.delete();
    for (int i = 0; i < HEADER_BYTES; i++) begin
        frame.push_back(byte_t'(xorshift()));
    end
    frame[ETHERTYPE_OFFSET]           = ethertype[15:8];
    frame[ETHERTYPE_OFFSET + 1]       = ethertype[7:0];
    frame[PROTOCOL_OFFSET]            = protocol;
    frame[UDP_DESTINATION_OFFSET]     = port[15:8];
    frame[UDP_DESTINATION_OFFSET + 1] = port[7:0];
    for (int i = 0; i < payload_length; i++) begin
        value = byte_t'(xorshift());
        payload.push_back(value);
        frame.push_back(value);
    end
    append_fcs();
endfunction

// Expected port words with the last marker on the final payload byte
function automatic void expect_payload(input udp_port_t port);
    foreach (payload[i]) begin
        expected_words.push_back({(i == payload.size() - 1), payload[i]});
        expected_ports.push_back(port);
    end
endfunction

`endif

// ==== verification/udp_receive_port_tb.sv ====
`timescale 1ns/1ps

module udp_receive_port_tb
    import udp_port_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 5000;

    logic           clock = 1'b0;
    logic           arst_n;
    stream_word_t   receive_data;
    logic           receive_data_enable;
    logic           receive_data_ready;
    stream_word_t   port_data;
    logic           port_data_valid;
    logic           port_data_ready;
    udp_port_t      udp_destination;

    logic [31:0]    rng_state = 32'd50;
    logic [31:0]    ready_draw;
    logic           random_ready;
    byte_t          frame [$];
    byte_t          payload [$];
    stream_word_t   expected_words [$];
    udp_port_t      expected_ports [$];
    stream_word_t   received_words [$];
    udp_port_t      received_ports [$];

    `include "frame_builder.svh"

    udp_receive_port dut0(
        .clock                  (clock),
        .arst_n                 (arst_n),
        .receive_data           (receive_data),
        .receive_data_enable    (receive_data_enable),
        .receive_data_ready     (receive_data_ready),
        .port_data              (port_data),
        .port_data_valid        (port_data_valid),
        .port_data_ready        (port_data_ready),
        .udp_destination        (udp_destination)
    );

    always #10 clock = ~clock;

    // Consumer ready is random only during the back-pressure test
    always @(posedge clock) begin
        #2;
        if (random_ready) begin
            ready_draw      = xorshift();
            port_data_ready = ready_draw[2];
        end else begin
            port_data_ready = 1'b1;
        end
    end

    always @(negedge clock) begin
        if (port_data_valid && port_data_ready) begin   // Transfer at the next edge
            received_words.push_back(port_data);
            received_ports.push_back(udp_destination);
        end
    end

    ////////////////////
    // Checks and waits

    task automatic report_failure(input string message);
        $display("%s", message);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic check_word(input string name, input stream_word_t actual,
                              input stream_word_t expected);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch at %0t: %s is %h, expected %h",
                                     $time, name, actual, expected));
        end
    endtask

    task automatic check_port(input string name, input udp_port_t actual,
                              input udp_port_t expected);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch at %0t: %s is %h, expected %h",
                                     $time, name, actual, expected));
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clock);
            #2;
        end
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!receive_data_ready) begin
            idle(1);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_failure("timed out waiting for receive_data_ready to rise");
            end
        end
    endtask

    task automatic wait_words(input int count);
        int cycles;
        cycles = 0;
        while (received_words.size() < count) begin
            idle(1);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_failure($sformatf("timed out waiting for %0d port words, got %0d",
                                         count, received_words.size()));
            end
        end
    endtask

    task automatic send_frame();
        for (int i = 0; i < frame.size(); i++) begin
            wait_ready();
            receive_data        = {(i == frame.size() - 1), frame[i]};
            receive_data_enable = 1'b1;
            idle(1);
            receive_data_enable = 1'b0;
        end
    endtask

    task automatic clear_queues();
        expected_words.delete();
        expected_ports.delete();
        received_words.delete();
        received_ports.delete();
    endtask

    task automatic compare_received();
        wait_words(expected_words.size());
        idle(8);
        if (received_words.size() != expected_words.size()) begin
            report_failure($sformatf("port output has %0d words, expected %0d",
                                     received_words.size(), expected_words.size()));
        end
        foreach (expected_words[i]) begin
            check_word("port_data", received_words[i], expected_words[i]);
            check_port("udp_destination", received_ports[i], expected_ports[i]);
        end
    endtask

    task automatic expect_dropped();
        wait_ready();
        idle(8);
        if (received_words.size() != 0) begin
            report_failure("a frame that should be dropped produced port output");
        end
    endtask

    ////////////////////
    // Directed tests

    task automatic deliver_good_frame();
        clear_queues();
        build_frame(16'h1234, ETHERTYPE_IPV4, IP_PROTOCOL_UDP, 20);
        expect_payload(16'h1234);
        send_frame();
        compare_received();
    endtask

    task automatic reject_bad_fcs();
        clear_queues();
        build_frame(16'h0bad, ETHERTYPE_IPV4, IP_PROTOCOL_UDP, 16);
        frame[frame.size() - 3] = frame[frame.size() - 3] ^ 8'h04;    // One FCS bit
        send_frame();
        expect_dropped();
        build_frame(16'h4321, ETHERTYPE_IPV4, IP_PROTOCOL_UDP, 12);
        expect_payload(16'h4321);
        send_frame();
        compare_received();
    endtask

    task automatic filter_headers();
        clear_queues();
        build_frame(16'h1000, 16'h86dd, IP_PROTOCOL_UDP, 10);     // IPv6
        send_frame();
        expect_dropped();
        build_frame(16'h1001, ETHERTYPE_IPV4, 8'd6, 10);          // TCP
        send_frame();
        expect_dropped();
    endtask

    task automatic drain_under_back_pressure();
        clear_queues();
        build_frame(16'hc001, ETHERTYPE_IPV4, IP_PROTOCOL_UDP, 200);
        expect_payload(16'hc001);
        random_ready = 1'b1;
        send_frame();
        compare_received();
        random_ready = 1'b0;
        idle(2);
    endtask

    task automatic stream_back_to_back();
        udp_port_t  ports [3];
        int         lengths [3];
        ports   = '{16'h0050, 16'h1f90, 16'hffee};
        lengths = '{1, 33, 64};
        clear_queues();
        for (int i = 0; i < 3; i++) begin
            build_frame(ports[i], ETHERTYPE_IPV4, IP_PROTOCOL_UDP, lengths[i]);
            expect_payload(ports[i]);
            send_frame();
        end
        compare_received();
        clear_queues();
        build_frame(16'h0101, ETHERTYPE_IPV4, IP_PROTOCOL_UDP, 0);   // 46 bytes
        send_frame();
        expect_dropped();
        // No payload here, so only a kept destination shows the drop
        check_port("udp_destination", udp_destination, ports[2]);
    endtask

    initial begin
        arst_n              = 1'b0;
        receive_data        = '0;
        receive_data_enable = 1'b0;
        port_data_ready     = 1'b1;
        random_ready        = 1'b0;
        repeat (5) @(posedge clock);
        #2;
        arst_n = 1'b1;
        idle(2);
        deliver_good_frame();
        reject_bad_fcs();
        filter_headers();
        drain_under_back_pressure();
        stream_back_to_back();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== verilog/udp_receive_port.sv ====
`timescale 1ns/1ps

module udp_receive_port
    import udp_port_pkg::*;
#(
    parameter int PAYLOAD_DEPTH = 1024
)(
    input   logic           clock,
    input   logic           arst_n,
    input   stream_word_t   receive_data,           // From the switch
    input   logic           receive_data_enable,
    output  logic           receive_data_ready,
    output  stream_word_t   port_data,              // To the consumer
    output  logic           port_data_valid,
    input   logic           port_data_ready,
    output  udp_port_t      udp_destination
);

    byte_t  fcs_data;
    logic   fcs_data_enable;
    logic   fcs_start;
    logic   fcs_good;

    slot_if #(.PAYLOAD_DEPTH(PAYLOAD_DEPTH)) slot();

    ////////////////////
    // Parser and FCS

    receive_controller #(.PAYLOAD_DEPTH(PAYLOAD_DEPTH))
    receive_controller(
        .clock                  (clock),
        .arst_n                 (arst_n),
        .receive_data           (receive_data),
        .receive_data_enable    (receive_data_enable),
        .receive_data_ready     (receive_data_ready),
        .fcs_data               (fcs_data),
        .fcs_data_enable        (fcs_data_enable),
        .fcs_start              (fcs_start),
        .fcs_good               (fcs_good),
        .udp_destination        (udp_destination),
        .slot                   (slot.controller)
    );

    fcs_checker fcs_checker(
        .clock                  (clock),
        .arst_n                 (arst_n),
        .fcs_data               (fcs_data),
        .fcs_data_enable        (fcs_data_enable),
        .fcs_start              (fcs_start),
        .fcs_good               (fcs_good)
    );

    ////////////////////
    // Payload slot and drain

    payload_fifo #(.PAYLOAD_DEPTH(PAYLOAD_DEPTH))
    payload_fifo(
        .clock                  (clock),
        .arst_n                 (arst_n),
        .slot                   (slot.fifo)
    );

    payload_drain #(.PAYLOAD_DEPTH(PAYLOAD_DEPTH))
    payload_drain(
        .clock                  (clock),
        .arst_n                 (arst_n),
        .slot                   (slot.drain),
        .port_data              (port_data),
        .port_data_valid        (port_data_valid),
        .port_data_ready        (port_data_ready)
    );

endmodule

// ==== verilog/payload_drain.sv ====
`timescale 1ns/1ps

module payload_drain
    import udp_port_pkg::*;
#(
    parameter int PAYLOAD_DEPTH = 1024
)(
    input   logic           clock,
    input   logic           arst_n,
    slot_if.drain           slot,
    output  stream_word_t   port_data,
    output  logic           port_data_valid,
    input   logic           port_data_ready
);

    localparam int LENGTH_WIDTH = $clog2(PAYLOAD_DEPTH + 1);

    logic [LENGTH_WIDTH-1:0]    remaining;      // Bytes still to pop
    logic                       stage_free;
    logic                       last_pop;

    // Output stage takes a byte when empty or when the consumer takes the current one
    assign stage_free       = !port_data_valid || port_data_ready;
    assign slot.read_enable = (remaining != '0) && stage_free;
    assign last_pop         = (remaining == LENGTH_WIDTH'(1));

    ////////////////////
    // Control

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            remaining       <= '0;
            port_data_valid <= 1'b0;
            slot.flush      <= 1'b0;
        end else begin
            slot.flush <= slot.bad_packet;  // Bad payload never leaves the slot

            if (slot.good_packet) begin
                remaining <= slot.payload_length;
            end else if (slot.read_enable) begin
                remaining <= remaining - 1'b1;
            end

            if (slot.read_enable) begin
                port_data_valid <= 1'b1;
            end else if (port_data_ready) begin
                port_data_valid <= 1'b0;
            end
        end
    end

    ////////////////////
    // Output stage

    always_ff @(posedge clock) begin
        if (slot.read_enable) begin
            port_data <= {last_pop, slot.read_data};    // Held while stalled
        end
    end

endmodule

// ==== verilog/payload_fifo.sv ====
`timescale 1ns/1ps

module payload_fifo
    import udp_port_pkg::*;
#(
    parameter int PAYLOAD_DEPTH = 1024
)(
    input   logic       clock,
    input   logic       arst_n,
    slot_if.fifo        slot
);

    localparam int ADDR_WIDTH  = $clog2(PAYLOAD_DEPTH);
    localparam int COUNT_WIDTH = $clog2(PAYLOAD_DEPTH + 1);

    byte_t                      memory [PAYLOAD_DEPTH];
    logic [ADDR_WIDTH-1:0]      write_pointer;
    logic [ADDR_WIDTH-1:0]      read_pointer;
    logic [COUNT_WIDTH-1:0]     count;
    logic                       do_write;
    logic                       do_read;

    function automatic logic [ADDR_WIDTH-1:0] next_pointer(input logic [ADDR_WIDTH-1:0] pointer);
        if (pointer == ADDR_WIDTH'(PAYLOAD_DEPTH - 1)) begin
            return '0;
        end
        return pointer + 1'b1;
    endfunction

    assign do_write = slot.write_enable && !slot.full;
    assign do_read  = slot.read_enable && !slot.empty;

    assign slot.read_data = memory[read_pointer];   // Fall-through head
    assign slot.empty     = (count == '0);
    assign slot.full      = (count == COUNT_WIDTH'(PAYLOAD_DEPTH));

    always_ff @(posedge clock) begin
        if (do_write) begin
            memory[write_pointer] <= slot.write_data;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            write_pointer <= '0;
            read_pointer  <= '0;
            count         <= '0;
        end else if (slot.flush) begin
            write_pointer <= '0;    // Drop everything in one cycle
            read_pointer  <= '0;
            count         <= '0;
        end else begin
            if (do_write) begin
                write_pointer <= next_pointer(write_pointer);
            end
            if (do_read) begin
                read_pointer <= next_pointer(read_pointer);
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== verilog/receive_controller.sv ====
`timescale 1ns/1ps

module receive_controller
    import udp_port_pkg::*;
#(
    parameter int PAYLOAD_DEPTH = 1024
)(
    input   logic               clock,
    input   logic               arst_n,
    input   stream_word_t       receive_data,
    input   logic               receive_data_enable,
    output  logic               receive_data_ready,
    output  byte_t              fcs_data,
    output  logic               fcs_data_enable,
    output  logic               fcs_start,
    input   logic               fcs_good,
    output  udp_port_t          udp_destination,
    slot_if.controller          slot
);

    localparam int COUNT_MAX    = HEADER_BYTES + PAYLOAD_DEPTH + FCS_BYTES + 1;
    localparam int COUNT_WIDTH  = $clog2(COUNT_MAX + 1);
    localparam int LENGTH_WIDTH = $clog2(PAYLOAD_DEPTH + 1);
    localparam int DELAY_WIDTH  = $clog2(FCS_BYTES + 1);

    typedef enum logic [1:0] {
        STATE_RECEIVE,
        STATE_VERDICT,
        STATE_DRAIN
    } state_t;

    state_t                     state;
    logic [COUNT_WIDTH-1:0]     byte_count;
    logic [LENGTH_WIDTH-1:0]    payload_count;
    logic [DELAY_WIDTH-1:0]     delay_count;
    byte_t                      delay_line [FCS_BYTES];
    logic [15:0]                ethertype;
    byte_t                      protocol;
    udp_port_t                  destination_capture;
    logic                       overflow;
    logic                       accepted;
    logic                       last_byte;
    logic                       in_payload;
    logic                       delay_full;
    logic                       frame_good;

    assign receive_data_ready = (state == STATE_RECEIVE);
    assign accepted           = receive_data_enable && receive_data_ready;
    assign last_byte          = accepted && receive_data[8];
    assign in_payload         = (byte_count >= COUNT_WIDTH'(HEADER_BYTES));
    assign delay_full         = (delay_count == DELAY_WIDTH'(FCS_BYTES));

    assign fcs_data        = receive_data[7:0];
    assign fcs_data_enable = accepted;
    assign fcs_start       = accepted && (byte_count == '0);

    // Oldest byte leaves once the FCS width of newer bytes sits behind it
    assign slot.write_data   = delay_line[FCS_BYTES-1];
    assign slot.write_enable = accepted && in_payload && delay_full && !slot.full;

    ////////////////////
    // Verdict

    assign frame_good = fcs_good
                     && (ethertype == ETHERTYPE_IPV4)
                     && (protocol == IP_PROTOCOL_UDP)
                     && (byte_count >= COUNT_WIDTH'(MIN_FRAME_BYTES))
                     && !overflow;

    assign slot.good_packet    = (state == STATE_VERDICT) && frame_good;
    assign slot.bad_packet     = (state == STATE_VERDICT) && !frame_good;
    assign slot.payload_length = payload_count;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state         <= STATE_RECEIVE;
            byte_count    <= '0;
            payload_count <= '0;
            delay_count   <= '0;
            overflow      <= 1'b0;
        end else begin
            case (state)
                STATE_RECEIVE: begin
                    if (accepted && byte_count != COUNT_WIDTH'(COUNT_MAX)) begin
                        byte_count <= byte_count + 1'b1;   // Saturates on long frames
                    end
                    if (accepted && in_payload && !delay_full) begin
                        delay_count <= delay_count + 1'b1;
                    end
                    if (slot.write_enable) begin
                        payload_count <= payload_count + 1'b1;
                    end
                    if (accepted && in_payload && delay_full && slot.full) begin
                        overflow <= 1'b1;
                    end
                    if (last_byte) begin
                        state <= STATE_VERDICT;
                    end
                end
                STATE_VERDICT: begin
                    byte_count    <= '0;
                    payload_count <= '0;
                    delay_count   <= '0;
                    overflow      <= 1'b0;
                    state         <= STATE_DRAIN;
                end
                STATE_DRAIN: begin
                    if (slot.empty) begin
                        state <= STATE_RECEIVE;     // One frame in the slot at a time
                    end
                end
                default: state <= STATE_RECEIVE;
            endcase
        end
    end

    ////////////////////
    // Header capture and delay line

    always_ff @(posedge clock) begin
        if (accepted) begin
            if (byte_count == COUNT_WIDTH'(ETHERTYPE_OFFSET)) begin
                ethertype[15:8] <= receive_data[7:0];
            end
            if (byte_count == COUNT_WIDTH'(ETHERTYPE_OFFSET + 1)) begin
                ethertype[7:0] <= receive_data[7:0];
            end
            if (byte_count == COUNT_WIDTH'(PROTOCOL_OFFSET)) begin
                protocol <= receive_data[7:0];
            end
            if (byte_count == COUNT_WIDTH'(UDP_DESTINATION_OFFSET)) begin
                destination_capture[15:8] <= receive_data[7:0];
            end
            if (byte_count == COUNT_WIDTH'(UDP_DESTINATION_OFFSET + 1)) begin
                destination_capture[7:0] <= receive_data[7:0];
            end
            if (in_payload) begin
                delay_line[0] <= receive_data[7:0];
                for (int i = 1; i < FCS_BYTES; i++) begin
                    delay_line[i] <= delay_line[i-1];
                end
            end
        end
        if (slot.good_packet) begin
            udp_destination <= destination_capture;   // Held for the whole drain
        end
    end

endmodule

// ==== verilog/fcs_checker.sv ====
`timescale 1ns/1ps

module fcs_checker
    import udp_port_pkg::*;
(
    input   logic       clock,
    input   logic       arst_n,
    input   byte_t      fcs_data,
    input   logic       fcs_data_enable,
    input   logic       fcs_start,
    output  logic       fcs_good
);

    crc_t   crc;
    crc_t   crc_seed;
    crc_t   crc_next;

    // Byte update with the least significant bit first
    function automatic crc_t crc_byte(input crc_t seed, input byte_t data);
        crc_t value;
        value = seed ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            if (value[0]) begin
                value = (value >> 1) ^ CRC_POLY;
            end else begin
                value = value >> 1;
            end
        end
        return value;
    endfunction

    assign crc_seed = fcs_start ? CRC_INIT : crc;   // Restart on the first byte
    assign crc_next = crc_byte(crc_seed, fcs_data);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            crc      <= CRC_INIT;
            fcs_good <= 1'b0;
        end else if (fcs_data_enable) begin
            crc      <= crc_next;
            fcs_good <= (crc_next == CRC_RESIDUE);
        end
    end

endmodule

// ==== verilog/slot_if.sv ====
`timescale 1ns/1ps

interface slot_if
    import udp_port_pkg::*;
#(
    parameter int PAYLOAD_DEPTH = 1024
)();

    localparam int LENGTH_WIDTH = $clog2(PAYLOAD_DEPTH + 1);

    byte_t                      write_data;
    logic                       write_enable;
    logic                       good_packet;        // One-cycle verdict pulses
    logic                       bad_packet;
    logic [LENGTH_WIDTH-1:0]    payload_length;
    byte_t                      read_data;          // Fall-through head byte
    logic                       read_enable;
    logic                       flush;
    logic                       empty;
    logic                       full;

    modport controller (
        output write_data, write_enable, good_packet, bad_packet, payload_length,
        input  empty, full
    );

    modport fifo (
        input  write_data, write_enable, read_enable, flush,
        output read_data, empty, full
    );

    modport drain (
        input  good_packet, bad_packet, payload_length, read_data,
        output read_enable, flush
    );

endinterface

// ==== verilog/udp_port_pkg.sv ====
package udp_port_pkg;

    typedef logic [8:0]  stream_word_t;     // Bit 8 marks the last byte
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [31:0] crc_t;

    ////////////////////
    // Frame layout

    localparam int ETHERTYPE_OFFSET       = 12;
    localparam int PROTOCOL_OFFSET        = 23;
    localparam int UDP_DESTINATION_OFFSET = 36;   // High byte first on the wire
    localparam int HEADER_BYTES           = 42;
    localparam int FCS_BYTES              = 4;
    localparam int MIN_FRAME_BYTES        = 47;

    localparam logic [15:0] ETHERTYPE_IPV4  = 16'h0800;
    localparam byte_t       IP_PROTOCOL_UDP = 8'd17;

    ////////////////////
    // Reflected CRC-32

    localparam crc_t CRC_POLY    = 32'hEDB8_8320;
    localparam crc_t CRC_INIT    = 32'hFFFF_FFFF;
    localparam crc_t CRC_RESIDUE = 32'hDEBB_20E3;  // Register value after a clean FCS

endpackage
